// ==== aes_key_expand.f ====
logic/aes_key_pkg.sv
logic/aes_sbox.sv
logic/aes_rcon.sv
logic/aes_sub_word.sv
logic/aes_key_mix.sv
logic/aes_key_expand.sv
sim/tb_aes_key_expand.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the key expansion testbench with Verilator and runs it
# The run fails when the log holds the fail message

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps -Mdir obj_dir \
  --top-module tb_aes_key_expand -f aes_key_expand.f \
  || { echo "build failed"; exit 1; }

./obj_dir/Vtb_aes_key_expand > "$LOG" 2>&1 \
  || { cat "$LOG"; echo "simulation aborted"; exit 1; }

cat "$LOG"
grep -q 'FAILED \*\*\*' "$LOG" && { echo "result: fail"; exit 1; } \
  || { echo "result: pass"; exit 0; }

// ==== sim/tb_aes_key_expand.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the AES-128/256 key expansion
// Expected keys come from a FIPS-197 schedule built in the testbench
// DUT words carry schedule byte a0 in bits 7:0, so words are byte swapped
// AES-256 forward runs enter round 0 with the key halves exchanged
//////////////////////////////////////////////////////////////////////

module tb_aes_key_expand;
  timeunit 1ns;
  timeprecision 100ps;

  // About 400 cycles of stimulus in total, the limit leaves ample margin
  localparam int MaxCycles     = 1000;
  localparam int NumRandomKeys = 20;

  // FIPS-197 appendix keys, word 0 in bits 31:0
  localparam logic [7:0][31:0] Fips128Key = {
    32'h0, 32'h0, 32'h0, 32'h0,
    32'h09cf4f3c, 32'habf71588, 32'h28aed2a6, 32'h2b7e1516
  };
  localparam logic [7:0][31:0] Fips256Key = {
    32'h0914dff4, 32'h2d9810a3, 32'h3b6108d7, 32'h1f352c07,
    32'h857d7781, 32'h2b73aef0, 32'h15ca71be, 32'h603deb10
  };

  //////////////////////////////////////////////////////////////////////
  // DUT signals and instance
  //////////////////////////////////////////////////////////////////////

  logic                  clk_i;
  logic                  rst_ni;
  logic                  clear_i;
  logic                  en_i;
  aes_key_pkg::ciph_op_e op_i;
  aes_key_pkg::key_len_e key_len_i;
  logic            [3:0] round_i;
  logic      [7:0][31:0] key_i;
  logic      [7:0][31:0] key_o;

  aes_key_expand i_dut (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .clear_i   ( clear_i   ),
    .en_i      ( en_i      ),
    .op_i      ( op_i      ),
    .key_len_i ( key_len_i ),
    .round_i   ( round_i   ),
    .key_i     ( key_i     ),
    .key_o     ( key_o     )
  );

  // Reference state
  logic [7:0]  sbox_table [256];
  logic [31:0] sched      [60];
  logic [31:0] rng_state;

  // Expected response, written on the rising edge and checked on the falling one
  logic                  exp_valid;
  logic      [7:0][31:0] exp_key;
  string                 test_name;
  int                    check_count;
  int                    error_count;

  // 100 ns clock
  initial begin : clock_gen
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model helpers
  //////////////////////////////////////////////////////////////////////

  // Multiply by x modulo 0x11B
  function automatic logic [7:0] xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // Shift and add product in GF(2^8)
  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] x;
    p = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        p = p ^ x;
      end
      x = xtime(x);
    end
    return p;
  endfunction

  // Brute force inverse, 0 maps to 0
  function automatic logic [7:0] gf_inv(input logic [7:0] a);
    logic [7:0] inv;
    inv = 8'h00;
    for (int y = 1; y < 256; y++) begin
      if (gf_mul(a, y[7:0]) == 8'h01) begin
        inv = y[7:0];
      end
    end
    return inv;
  endfunction

  // S-box from the field inverse and the affine map
  task automatic build_sbox_table();
    logic [7:0] b;
    for (int x = 0; x < 256; x++) begin
      b = gf_inv(x[7:0]);
      sbox_table[x] = b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]}
                      ^ {b[3:0], b[7:4]} ^ 8'h63;
    end
  endtask

  // Word helpers in FIPS byte order, a0 in bits 31:24
  function automatic logic [31:0] rot_word_fips(input logic [31:0] w);
    return {w[23:0], w[31:24]};
  endfunction

  function automatic logic [31:0] sub_word_fips(input logic [31:0] w);
    return {sbox_table[w[31:24]], sbox_table[w[23:16]], sbox_table[w[15:8]], sbox_table[w[7:0]]};
  endfunction

  // DUT word order keeps a0 in the low byte
  function automatic logic [31:0] swap_bytes(input logic [31:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  // Full FIPS-197 expansion into sched, 44 or 60 words
  function automatic void build_schedule(input logic [7:0][31:0] cipher_key, input bit is256);
    int          nk;
    int          total;
    logic [31:0] temp;
    logic  [7:0] rc;
    nk    = is256 ? 8 : 4;
    total = is256 ? 60 : 44;
    rc    = 8'h01;
    for (int i = 0; i < nk; i++) begin
      sched[i] = cipher_key[i];
    end
    for (int i = nk; i < total; i++) begin
      temp = sched[i-1];
      if (i % nk == 0) begin
        temp = sub_word_fips(rot_word_fips(temp)) ^ {rc, 24'h000000};
        rc   = xtime(rc);
      end else if (nk == 8 && i % nk == 4) begin
        temp = sub_word_fips(temp);
      end
      sched[i] = sched[i-nk] ^ temp;
    end
  endfunction

  // Marsaglia xorshift32
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Spot words printed in the FIPS-197 appendix
  task automatic check_reference();
    build_schedule(Fips128Key, 1'b0);
    assert (sched[43] === 32'hb6630ca6) else begin
      error_count++;
      $display("error: sched[43] = %h, expected b6630ca6", sched[43]);
    end
    build_schedule(Fips256Key, 1'b1);
    assert (sched[59] === 32'h706c631e) else begin
      error_count++;
      $display("error: sched[59] = %h, expected 706c631e", sched[59]);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic apply_reset();
    rst_ni <= 1'b0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
  endtask

  // One full schedule walk, optionally stalling en_i in hold_round
  task automatic run_schedule(input logic [7:0][31:0] cipher_key, input bit is256,
                              input bit inv, input int hold_round, input int hold_cycles);
    logic [7:0][31:0] cur;
    logic [7:0][31:0] expect_words;
    int               nwords;
    int               first_round;
    int               num_steps;
    int               start;
    int               rnd;
    int               lo;
    int               reps;
    build_schedule(cipher_key, is256);
    nwords      = is256 ? 8 : 4;
    first_round = inv ? (is256 ? 13 : 10) : (is256 ? 0 : 1);
    num_steps   = is256 ? (inv ? 13 : 14) : 10;
    start       = inv ? (is256 ? 52 : 40) : 0;

    // Starting key, the forward AES-256 one with exchanged halves
    for (int k = 0; k < 8; k++) begin
      cur[k] = 32'h0;
      if (is256 && !inv) begin
        cur[k] = swap_bytes(sched[(k + 4) % 8]);
      end else if (k < nwords) begin
        cur[k] = swap_bytes(sched[start + k]);
      end
    end

    // Clear picks the Rcon start value from op_i and key_len_i
    @(posedge clk_i);
    clear_i   <= 1'b1;
    en_i      <= 1'b0;
    op_i      <= inv ? aes_key_pkg::CIPH_INV : aes_key_pkg::CIPH_FWD;
    key_len_i <= is256 ? aes_key_pkg::AES_256 : aes_key_pkg::AES_128;
    exp_valid <= 1'b0;

    for (int s = 0; s < num_steps; s++) begin
      rnd = inv ? first_round - s : first_round + s;
      // Schedule words expected in key_o for this round
      lo  = inv ? 4 * rnd - 4 : 4 * rnd;
      for (int k = 0; k < 8; k++) begin
        if (k < nwords || inv) begin
          expect_words[k] = swap_bytes(sched[lo + k]);
        end else begin
          // AES-128 upper half echoes the round key that went in
          expect_words[k] = swap_bytes(sched[lo + k - 8]);
        end
      end
      reps = (rnd == hold_round) ? hold_cycles + 1 : 1;
      for (int rep = 0; rep < reps; rep++) begin
        @(posedge clk_i);
        clear_i    <= 1'b0;
        key_i      <= cur;
        round_i    <= rnd[3:0];
        // Advance only in the last cycle of this round
        en_i       <= (rep == reps - 1);
        exp_key    <= expect_words;
        exp_valid  <= 1'b1;
        @(negedge clk_i);
      end
      // Feed the result back as the next full key
      cur = key_o;
    end

    @(posedge clk_i);
    en_i      <= 1'b0;
    exp_valid <= 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin : compare
    if (exp_valid) begin
      for (int k = 0; k < 8; k++) begin
        check_count++;
        assert (key_o[k] === exp_key[k]) else begin
          error_count++;
          $display("error: key_o[%0d] = %h, expected %h (%s, round %0d)",
                   k, key_o[k], exp_key[k], test_name, round_i);
        end
      end
    end
  end

  // Ends a hung run
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < MaxCycles) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles, checks: %0d, errors: %0d",
             MaxCycles, check_count, error_count);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin : stimulus
    logic [7:0][31:0] rand_key;
    clear_i     <= 1'b0;
    en_i        <= 1'b0;
    op_i        <= aes_key_pkg::CIPH_FWD;
    key_len_i   <= aes_key_pkg::AES_128;
    round_i     <= 4'd0;
    key_i       <= '0;
    exp_valid   <= 1'b0;
    exp_key     <= '0;
    rst_ni      <= 1'b0;
    check_count = 0;
    error_count = 0;
    rng_state   = 32'd41182;
    test_name   = "reference";

    build_sbox_table();
    check_reference();
    apply_reset();

    test_name = "aes128 forward";
    run_schedule(Fips128Key, 1'b0, 1'b0, -1, 0);
    test_name = "aes256 forward";
    run_schedule(Fips256Key, 1'b1, 1'b0, -1, 0);
    test_name = "aes128 inverse";
    run_schedule(Fips128Key, 1'b0, 1'b1, -1, 0);
    test_name = "aes256 inverse";
    run_schedule(Fips256Key, 1'b1, 1'b1, -1, 0);

    // All four length and direction pairs in turn
    test_name = "random keys";
    for (int n = 0; n < NumRandomKeys; n++) begin
      for (int k = 0; k < 8; k++) begin
        rng_state   = xorshift32(rng_state);
        rand_key[k] = rng_state;
      end
      run_schedule(rand_key, n[0], n[1], -1, 0);
    end

    // Stall round 5 for four extra cycles
    test_name = "rcon hold";
    run_schedule(Fips128Key, 1'b0, 1'b0, 5, 4);

    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== logic/aes_key_expand.sv ====
//////////////////////////////////////////////////////////////////////
// AES-128/256 key expansion, one round per en_i strobe
// The caller owns the full key and feeds key_o back into key_i
// Pulse clear_i before the first round, Rcon is 0 after reset
//////////////////////////////////////////////////////////////////////

module aes_key_expand (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  logic                  en_i,
  input  aes_key_pkg::ciph_op_e op_i,
  input  aes_key_pkg::key_len_e key_len_i,
  input  logic            [3:0] round_i,
  input  logic [aes_key_pkg::NumKeyWords-1:0][aes_key_pkg::WordWidth-1:0] key_i,
  output logic [aes_key_pkg::NumKeyWords-1:0][aes_key_pkg::WordWidth-1:0] key_o
);

  logic                        [7:0] rcon;
  logic                              use_rcon;
  logic [aes_key_pkg::WordWidth-1:0] irregular;

  // Round constant state, the only register in the design
  aes_rcon i_rcon (
    .clk_i      ( clk_i     ),
    .rst_ni     ( rst_ni    ),
    .clear_i    ( clear_i   ),
    .en_i       ( en_i      ),
    .op_i       ( op_i      ),
    .key_len_i  ( key_len_i ),
    .round_i    ( round_i   ),
    .rcon_o     ( rcon      ),
    .use_rcon_o ( use_rcon  )
  );

  // RotWord, SubWord and Rcon
  aes_sub_word i_sub_word (
    .op_i        ( op_i      ),
    .key_len_i   ( key_len_i ),
    .round_i     ( round_i   ),
    .key_i       ( key_i     ),
    .rcon_i      ( rcon      ),
    .use_rcon_i  ( use_rcon  ),
    .irregular_o ( irregular )
  );

  // Word chaining into the next full key
  aes_key_mix i_key_mix (
    .op_i        ( op_i      ),
    .key_len_i   ( key_len_i ),
    .round_i     ( round_i   ),
    .key_i       ( key_i     ),
    .irregular_i ( irregular ),
    .key_o       ( key_o     )
  );

endmodule

// ==== logic/aes_key_mix.sv ====
//////////////////////////////////////////////////////////////////////
// Regular part of the key schedule, chains the irregular word
// with the current full key into the next full key
// AES-128 keeps its key in words 3:0, words 7:4 only echo
//////////////////////////////////////////////////////////////////////

module aes_key_mix (
  input  aes_key_pkg::ciph_op_e op_i,
  input  aes_key_pkg::key_len_e key_len_i,
  input  logic            [3:0] round_i,
  input  logic [aes_key_pkg::NumKeyWords-1:0][aes_key_pkg::WordWidth-1:0] key_i,
  input  logic [aes_key_pkg::WordWidth-1:0] irregular_i,
  output logic [aes_key_pkg::NumKeyWords-1:0][aes_key_pkg::WordWidth-1:0] key_o
);

  always_comb begin : key_mix
    // Half swap as the base value, also the AES-256 round 0 result
    key_o = {key_i[3:0], key_i[7:4]};

    if (key_len_i == aes_key_pkg::AES_128) begin
      //////////////////////////////////////////////////////////////////////
      // AES-128
      //////////////////////////////////////////////////////////////////////

      // Upper words unused, just echo the lower half
      key_o[7:4] = key_i[3:0];
      key_o[0]   = irregular_i ^ key_i[0];

      if (op_i == aes_key_pkg::CIPH_FWD) begin
        // w[i] = w[i-1] ^ w[i-4], running through the new words
        for (int i = 1; i < 4; i++) begin
          key_o[i] = key_o[i-1] ^ key_i[i];
        end
      end else begin
        // Backwards each older word is the XOR of two neighbours
        for (int i = 1; i < 4; i++) begin
          key_o[i] = key_i[i-1] ^ key_i[i];
        end
      end

    end else if (round_i != 4'd0) begin
      //////////////////////////////////////////////////////////////////////
      // AES-256, rounds after 0
      //////////////////////////////////////////////////////////////////////

      if (op_i == aes_key_pkg::CIPH_FWD) begin
        // Old upper half moves down
        key_o[3:0] = key_i[7:4];
        // New upper half chained from the irregular word
        key_o[4]   = irregular_i ^ key_i[0];
        for (int i = 1; i < 4; i++) begin
          key_o[i+4] = key_o[i+3] ^ key_i[i];
        end
      end else begin
        // Old lower half moves up
        key_o[7:4] = key_i[3:0];
        // New lower half recovered from the old upper half
        key_o[0]   = irregular_i ^ key_i[4];
        for (int i = 0; i < 3; i++) begin
          key_o[i+1] = key_i[4+i] ^ key_i[5+i];
        end
      end
    end
    // AES-256 round 0 keeps the swapped halves from above
  end

endmodule

// ==== logic/aes_sub_word.sv ====
//////////////////////////////////////////////////////////////////////
// Irregular word of the key schedule, RotWord then SubWord then Rcon
// Purely combinational, four table S-boxes work in parallel
// AES-256 even rounds skip RotWord
//////////////////////////////////////////////////////////////////////

module aes_sub_word (
  input  aes_key_pkg::ciph_op_e op_i,
  input  aes_key_pkg::key_len_e key_len_i,
  input  logic            [3:0] round_i,
  input  logic [aes_key_pkg::NumKeyWords-1:0][aes_key_pkg::WordWidth-1:0] key_i,
  input  logic            [7:0] rcon_i,
  input  logic                  use_rcon_i,
  output logic [aes_key_pkg::WordWidth-1:0] irregular_o
);

  logic [aes_key_pkg::WordWidth-1:0] rot_word_in;
  logic [aes_key_pkg::WordWidth-1:0] rot_word_out;
  logic [aes_key_pkg::WordWidth-1:0] sub_word_in;
  logic [aes_key_pkg::WordWidth-1:0] sub_word_out;
  logic                              use_rot_word;
  logic                        [7:0] rcon_add;

  //////////////////////////////////////////////////////////////////////
  // RotWord
  //////////////////////////////////////////////////////////////////////

  // Source word of the irregular path
  // Inverse AES-128 rebuilds the older word 3 as key word 3 ^ key word 2
  always_comb begin : rot_word_in_mux
    if (key_len_i == aes_key_pkg::AES_128) begin
      if (op_i == aes_key_pkg::CIPH_FWD) begin
        rot_word_in = key_i[3];
      end else begin
        rot_word_in = key_i[3] ^ key_i[2];
      end
    end else begin
      if (op_i == aes_key_pkg::CIPH_FWD) begin
        rot_word_in = key_i[7];
      end else begin
        rot_word_in = key_i[3];
      end
    end
  end

  assign rot_word_out = aes_key_pkg::aes_rot_word(rot_word_in);

  // No rotation in AES-256 even rounds
  assign use_rot_word = !((key_len_i == aes_key_pkg::AES_256) && !round_i[0]);
  assign sub_word_in  = use_rot_word ? rot_word_out : rot_word_in;

  //////////////////////////////////////////////////////////////////////
  // SubWord
  //////////////////////////////////////////////////////////////////////

  // Each byte through its own S-box
  for (genvar i = 0; i < 4; i++) begin : gen_sbox
    aes_sbox i_sbox (
      .data_i ( sub_word_in[8*i +: 8]  ),
      .data_o ( sub_word_out[8*i +: 8] )
    );
  end

  // Rcon only touches byte 0
  assign rcon_add    = use_rcon_i ? rcon_i : 8'h00;
  assign irregular_o = {sub_word_out[aes_key_pkg::WordWidth-1:8], sub_word_out[7:0] ^ rcon_add};

endmodule

// ==== logic/aes_rcon.sv ====
//////////////////////////////////////////////////////////////////////
// Round constant register for the AES-128/256 key schedule
// Holds 0 after reset, clear_i must load a start value before use
// Advances only on en_i in rounds that consume Rcon
//////////////////////////////////////////////////////////////////////

module aes_rcon (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  logic                  en_i,
  input  aes_key_pkg::ciph_op_e op_i,
  input  aes_key_pkg::key_len_e key_len_i,
  input  logic            [3:0] round_i,
  output logic            [7:0] rcon_o,
  output logic                  use_rcon_o
);

  logic [7:0] rcon_init;
  logic [7:0] rcon_d;
  logic [7:0] rcon_q;
  logic       rcon_we;

  // AES-256 alternates, even rounds only run SubWord
  assign use_rcon_o = !((key_len_i == aes_key_pkg::AES_256) && !round_i[0]);

  // Start value per direction and key length
  always_comb begin : rcon_start
    if (op_i == aes_key_pkg::CIPH_FWD) begin
      rcon_init = aes_key_pkg::RconFwdInit;
    end else if (key_len_i == aes_key_pkg::AES_128) begin
      rcon_init = aes_key_pkg::RconInv128Init;
    end else begin
      rcon_init = aes_key_pkg::RconInv256Init;
    end
  end

  // Next value, doubling going forward and halving going back
  always_comb begin : rcon_next
    if (clear_i) begin
      rcon_d = rcon_init;
    end else if (op_i == aes_key_pkg::CIPH_FWD) begin
      rcon_d = aes_key_pkg::aes_mul2(rcon_q);
    end else begin
      rcon_d = aes_key_pkg::aes_div2(rcon_q);
    end
  end

  // Clear always wins, advance only when this round used Rcon
  assign rcon_we = clear_i | (en_i & use_rcon_o);

  always_ff @(posedge clk_i or negedge rst_ni) begin : rcon_reg
    if (!rst_ni) begin
      rcon_q <= 8'h00;
    end else if (rcon_we) begin
      rcon_q <= rcon_d;
    end
  end

  assign rcon_o = rcon_q;

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // Every start value is a nonzero field element
  rcon_valid_after_clear_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    clear_i |=> (rcon_o != 8'h00)
  );

  // Selectors drive the start value and the update, they must be known
  rcon_sel_known_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$isunknown({op_i, key_len_i})
  );

endmodule

// ==== logic/aes_sbox.sv ====
//////////////////////////////////////////////////////////////////////
// Forward AES S-box, purely combinational
// The inverse key schedule also uses this forward table
//////////////////////////////////////////////////////////////////////

module aes_sbox (
  input  logic [7:0] data_i,
  output logic [7:0] data_o
);

  // One table row of sixteen bytes, column 0 in the top byte
  logic [127:0] row;

  //////////////////////////////////////////////////////////////////////
  // Row select on the upper nibble
  //////////////////////////////////////////////////////////////////////

  always_comb begin : sbox_row
    unique case (data_i[7:4])
      4'h0: row = 128'h637c777b_f26b6fc5_3001672b_fed7ab76;
      4'h1: row = 128'hca82c97d_fa5947f0_add4a2af_9ca472c0;
      4'h2: row = 128'hb7fd9326_363ff7cc_34a5e5f1_71d83115;
      4'h3: row = 128'h04c723c3_1896059a_071280e2_eb27b275;
      4'h4: row = 128'h09832c1a_1b6e5aa0_523bd6b3_29e32f84;
      4'h5: row = 128'h53d100ed_20fcb15b_6acbbe39_4a4c58cf;
      4'h6: row = 128'hd0efaafb_434d3385_45f9027f_503c9fa8;
      4'h7: row = 128'h51a3408f_929d38f5_bcb6da21_10fff3d2;
      4'h8: row = 128'hcd0c13ec_5f974417_c4a77e3d_645d1973;
      4'h9: row = 128'h60814fdc_222a9088_46eeb814_de5e0bdb;
      4'ha: row = 128'he0323a0a_4906245c_c2d3ac62_9195e479;
      4'hb: row = 128'he7c8376d_8dd54ea9_6c56f4ea_657aae08;
      4'hc: row = 128'hba78252e_1ca6b4c6_e8dd741f_4bbd8b8a;
      4'hd: row = 128'h703eb566_4803f60e_613557b9_86c11d9e;
      4'he: row = 128'he1f89811_69d98e94_9b1e87e9_ce5528df;
      4'hf: row = 128'h8ca1890d_bfe64268_41992d0f_b054bb16;
      default: row = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Column select on the lower nibble
  //////////////////////////////////////////////////////////////////////

  // Column 0 sits in bits 127:120, column 15 in bits 7:0
  assign data_o = row[8 * (15 - int'(data_i[3:0])) +: 8];

endmodule

// ==== logic/aes_key_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared codes, constants and byte helpers for the key schedule
// Only AES-128 and AES-256 exist, so key length is a single bit
// Field arithmetic assumes the AES polynomial 0x11B
//////////////////////////////////////////////////////////////////////

package aes_key_pkg;

  //////////////////////////////////////////////////////////////////////
  // Codes
  //////////////////////////////////////////////////////////////////////

  // Direction of the schedule
  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_op_e;

  // Supported key lengths
  typedef enum logic {
    AES_128 = 1'b0,
    AES_256 = 1'b1
  } key_len_e;

  //////////////////////////////////////////////////////////////////////
  // Sizes and Rcon start values
  //////////////////////////////////////////////////////////////////////

  // Full key register holds eight words, AES-128 uses the lower four
  localparam int NumKeyWords = 8;
  localparam int WordWidth   = 32;

  // Rcon of the first forward round
  localparam logic [7:0] RconFwdInit    = 8'h01;
  // Rcon of round 10 for AES-128
  localparam logic [7:0] RconInv128Init = 8'h36;
  // Rcon of the last Rcon round for AES-256
  localparam logic [7:0] RconInv256Init = 8'h40;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Multiply by x in GF(2^8)
  function automatic logic [7:0] aes_mul2(logic [7:0] in);
    logic [7:0] out;
    out = {in[6:0], 1'b0};
    // Reduce when the top bit falls out
    if (in[7]) begin
      out = out ^ 8'h1b;
    end
    return out;
  endfunction

  // Divide by x in GF(2^8), the inverse of aes_mul2
  function automatic logic [7:0] aes_div2(logic [7:0] in);
    logic [7:0] out;
    out = {1'b0, in[7:1]};
    // Odd input means a reduction took place on the way up
    // 0x8d is (0x1b >> 1) with the lost top bit restored
    if (in[0]) begin
      out = out ^ 8'h8d;
    end
    return out;
  endfunction

  // RotWord, byte 1 lands in byte 0 and byte 0 wraps to byte 3
  function automatic logic [WordWidth-1:0] aes_rot_word(logic [WordWidth-1:0] in);
    return {in[7:0], in[WordWidth-1:8]};
  endfunction

endpackage
